/* DivUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module DivUnit #(
    parameter int N = MulDivTypes::DATA_WIDTH
) (
    input logic clk,
    input logic rstN,
    input logic enable,
    input logic stall,
    input logic flush,
    input logic isSigned,
    input logic [N-1:0] dividend,
    input logic [N-1:0] divisor,
    output logic done,
    output logic [N-1:0] quotient,
    output logic [N-1:0] remnant
);
    import MulDivTypes::*;

    logic [N-1:0] stepToken;   // a single bit walks down once per quotient bit.
    logic fixPending;          // the next cycle applies the signs.
    logic started;             // an enable was taken since the last flush.

    logic [N-1:0] partRem;     // partial remainder that stays below the divisor.
    logic [N-1:0] partQuo;     // dividend bits shift out as quotient bits shift in.
    logic [N-1:0] magDivisor;
    logic negQuo;
    logic negRem;
    logic divByZero;
    logic overflow;

    logic dividendNeg;
    logic divisorNeg;
    logic [N-1:0] magDividendIn;
    logic [N-1:0] magDivisorIn;
    logic [N:0] trial;         // the top bit is the borrow of the trial subtraction.

    always_comb begin
        dividendNeg = isSigned && dividend[N-1];
        divisorNeg = isSigned && divisor[N-1];
        magDividendIn = dividendNeg ? -dividend : dividend;
        magDivisorIn = divisorNeg ? -divisor : divisor;
        trial = {partRem, partQuo[N-1]} - {1'b0, magDivisor};
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stepToken <= '0;
            fixPending <= 1'b0;
            done <= 1'b0;
            started <= 1'b0;
        end
        else if (flush) begin
            stepToken <= '0;
            fixPending <= 1'b0;
            done <= 1'b0;
            started <= 1'b0;
        end
        else if (!stall) begin
            done <= fixPending;  // high for one cycle.
            fixPending <= stepToken[0];
            if (enable) begin
                stepToken <= {1'b1, {(N-1){1'b0}}};
                started <= 1'b1;
            end
            else begin
                stepToken <= stepToken >> 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (enable) begin
                // work on magnitudes and apply the signs at the end.
                partRem <= '0;
                partQuo <= magDividendIn;
                magDivisor <= magDivisorIn;
                negQuo <= dividendNeg ^ divisorNeg;
                negRem <= dividendNeg;  // the remainder takes the sign of the dividend.
                divByZero <= (divisor == '0);
                overflow <= isSigned && (dividend == {1'b1, {(N-1){1'b0}}}) && (divisor == '1);
            end
            else if (|stepToken) begin
                if (!trial[N]) begin
                    partRem <= trial[N-1:0];  // the divisor fits so the difference is kept.
                    partQuo <= {partQuo[N-2:0], 1'b1};
                end
                else begin
                    partRem <= {partRem[N-2:0], partQuo[N-1]};  // restore by shifting only.
                    partQuo <= {partQuo[N-2:0], 1'b0};
                end
            end

            if (fixPending) begin
                if (divByZero) begin
                    // all ones, and the remainder is the dividend itself.
                    quotient <= '1;
                    remnant <= negRem ? -partRem : partRem;
                end
                else if (overflow) begin
                    quotient <= {1'b1, {(N-1){1'b0}}};  // the most negative value again.
                    remnant <= '0;
                end
                else begin
                    quotient <= negQuo ? -partQuo : partQuo;
                    remnant <= negRem ? -partRem : partRem;
                end
            end
        end
    end

    // a flush leaves nothing behind that could still finish.
    assert property (@(posedge clk) disable iff (!rstN) $rose(done) |-> started)
        else $error("done without an enable since the last flush");

    // setup and fix-up add a fixed overhead on top of the N steps.
    // a new enable restarts the divider, so only an undisturbed run must finish on time.
    assert property (@(posedge clk) disable iff (!rstN || flush)
        (enable && !stall) ##1 (!stall && !enable)[*(N + DIV_CYCLES - DATA_WIDTH - 1)] |=> done)
        else $error("divider latency differs from DIV_CYCLES");
endmodule

`default_nettype wire

/* Makefile */
TOP := MulDivCoreTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir -o sim$(TOP)
	./obj_dir/sim$(TOP) | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation reported a failure, see sim.log"; \
		exit 1; \
	fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* MulDivCore.sv */
`timescale 1ns/1ps
`default_nettype none

module MulDivCore (
    input logic clk,
    input logic rstN,
    input logic reqValid,
    output logic reqReady,
    input MulDivTypes::MulDivCommand reqCommand,
    input logic [MulDivTypes::DATA_WIDTH-1:0] reqSrc1,
    input logic [MulDivTypes::DATA_WIDTH-1:0] reqSrc2,
    input logic stall,
    input logic flush,
    output logic respValid,
    output logic [MulDivTypes::DATA_WIDTH-1:0] respResult
);
    MulDivIf mulDivIf ();  // issue stage to execute block.

    MulDivIssueStage m_MulDivIssueStage (
        .clk,
        .rstN,
        .reqValid,
        .reqReady,
        .reqCommand,
        .reqSrc1,
        .reqSrc2,
        .stall,
        .flush,
        .port(mulDivIf)
    );

    MulDivUnit m_MulDivUnit (
        .clk,
        .rstN,
        .port(mulDivIf)
    );

    // the response is the unit's done and result as they are.
    assign respValid = mulDivIf.done;
    assign respResult = mulDivIf.result;
endmodule

`default_nettype wire

/* MulDivCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module MulDivCoreTb;
    import MulDivTypes::*;

    localparam int CORNER_COUNT = 5;
    localparam int RANDOM_MUL_PAIRS = 50;
    localparam int RANDOM_DIV_PAIRS = 20;
    localparam int SPECIAL_OPS = 12;  // eight divisions by zero and four overflow cases.
    // handshake, stall and flush run two operations each.
    localparam int OP_COUNT = 4 * CORNER_COUNT * CORNER_COUNT + 4 * RANDOM_MUL_PAIRS
        + 4 * RANDOM_DIV_PAIRS + SPECIAL_OPS + 6;
    localparam int TIMEOUT_CYCLES = OP_COUNT * 40 + 200;  // the margin covers reset and the flush gap.
    localparam logic [DATA_WIDTH-1:0] MOST_NEGATIVE = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    localparam logic [DATA_WIDTH-1:0] MOST_POSITIVE = {1'b0, {(DATA_WIDTH-1){1'b1}}};

    logic clk;
    logic rstN;
    logic reqValid;
    logic reqReady;
    MulDivCommand reqCommand;
    logic [DATA_WIDTH-1:0] reqSrc1;
    logic [DATA_WIDTH-1:0] reqSrc2;
    logic stall;
    logic flush;
    logic respValid;
    logic [DATA_WIDTH-1:0] respResult;

    int resultErrors;
    int latencyErrors;
    int protocolErrors;
    int cycleCount;
    logic [DATA_WIDTH-1:0] corners [CORNER_COUNT];

    MulDivCore u_MulDivCore (
        .clk,
        .rstN,
        .reqValid,
        .reqReady,
        .reqCommand,
        .reqSrc1,
        .reqSrc2,
        .stall,
        .flush,
        .respValid,
        .respResult
    );

    always #5 clk = ~clk;  // 10 ns period.

    // ends a run that waits forever on a response.
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycleCount);
            $display("Test failed");
            $finish;
        end
    end

    // RV32M results as the ISA defines them.
    function automatic logic [DATA_WIDTH-1:0] expectedResult(input MulDivCommand cmd,
            input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
        logic [2*DATA_WIDTH-1:0] wideA;
        logic [2*DATA_WIDTH-1:0] wideB;
        logic [2*DATA_WIDTH-1:0] product;
        logic signed [DATA_WIDTH-1:0] signedA;
        logic signed [DATA_WIDTH-1:0] signedB;
        logic overflow;
        signedA = a;
        signedB = b;
        // a signed operand is sign extended, an unsigned one zero extended.
        wideA = (cmd == MulDivCommand_Mulhu) ? {{DATA_WIDTH{1'b0}}, a}
            : {{DATA_WIDTH{a[DATA_WIDTH-1]}}, a};
        wideB = (cmd == MulDivCommand_Mul || cmd == MulDivCommand_Mulh)
            ? {{DATA_WIDTH{b[DATA_WIDTH-1]}}, b} : {{DATA_WIDTH{1'b0}}, b};
        product = wideA * wideB;  // the low 64 bits of this product are exact.
        overflow = (a == MOST_NEGATIVE) && (b == '1);
        case (cmd)
            MulDivCommand_Mul: return product[DATA_WIDTH-1:0];
            MulDivCommand_Mulh, MulDivCommand_Mulhsu, MulDivCommand_Mulhu: begin
                return product[2*DATA_WIDTH-1:DATA_WIDTH];
            end
            MulDivCommand_Div: begin
                if (b == '0) return '1;
                if (overflow) return a;
                return signedA / signedB;  // truncates toward zero as RISC-V does.
            end
            MulDivCommand_Divu: return (b == '0) ? '1 : a / b;
            MulDivCommand_Rem: begin
                if (b == '0) return a;
                if (overflow) return '0;
                return signedA % signedB;  // takes the sign of the dividend.
            end
            default: return (b == '0) ? a : a % b;
        endcase
    endfunction

    // accepting edge, one cycle for the enable pulse, then the unit.
    function automatic int expectedLatency(input MulDivCommand cmd, input int stalled);
        return (cmd[2] ? DIV_CYCLES : MUL_STAGES) + 1 + stalled;  // bit 2 marks the divider.
    endfunction

    task automatic checkResult(input MulDivCommand cmd, input logic [DATA_WIDTH-1:0] expected,
            input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            resultErrors++;
            $display("[ERROR] %0t ns respResult (%s): expected %h, actual %h",
                $time, cmd.name(), expected, actual);
        end
    endtask

    task automatic checkLatency(input MulDivCommand cmd, input int expected, input int actual);
        if (actual != expected) begin
            latencyErrors++;
            $display("[ERROR] %0t ns respValid latency (%s): expected %0d, actual %0d",
                $time, cmd.name(), expected, actual);
        end
    endtask

    // returns at the edge where the request is taken.
    task automatic sendRequest(input MulDivCommand cmd, input logic [DATA_WIDTH-1:0] a,
            input logic [DATA_WIDTH-1:0] b);
        reqValid <= 1'b1;
        reqCommand <= cmd;
        reqSrc1 <= a;
        reqSrc2 <= b;
        @(posedge clk);
        while (!reqReady) @(posedge clk);
        reqValid <= 1'b0;
    endtask

    // counts edges from acceptance up to the one that samples respValid high.
    task automatic waitResponse(input int stallAt, input int stallLen,
            output logic [DATA_WIDTH-1:0] result, output int latency);
        logic seen;
        seen = 1'b0;
        latency = 0;
        while (!seen) begin
            @(posedge clk);
            latency++;
            if (reqReady) begin
                protocolErrors++;
                $display("reqReady was high at %0t ns while an operation was running", $time);
            end
            if (respValid) begin
                seen = 1'b1;
                result = respResult;
            end
            if (stallLen > 0 && latency == stallAt) stall <= 1'b1;
            if (stallLen > 0 && latency == stallAt + stallLen) stall <= 1'b0;
        end
    endtask

    task automatic runOp(input MulDivCommand cmd, input logic [DATA_WIDTH-1:0] a,
            input logic [DATA_WIDTH-1:0] b, input int stallAt, input int stallLen);
        logic [DATA_WIDTH-1:0] result;
        int latency;
        sendRequest(cmd, a, b);
        waitResponse(stallAt, stallLen, result, latency);
        checkResult(cmd, expectedResult(cmd, a, b), result);
        checkLatency(cmd, expectedLatency(cmd, stallLen), latency);
    endtask

    task automatic testMultiplies();
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < CORNER_COUNT; i++) begin
                for (int j = 0; j < CORNER_COUNT; j++) begin
                    runOp(MulDivCommand'(c), corners[i], corners[j], 0, 0);
                end
            end
        end
        for (int i = 0; i < RANDOM_MUL_PAIRS; i++) begin
            a = $urandom();
            b = $urandom();
            for (int c = 0; c < 4; c++) runOp(MulDivCommand'(c), a, b, 0, 0);
        end
    endtask

    task automatic testDivides();
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        for (int i = 0; i < RANDOM_DIV_PAIRS; i++) begin
            a = $urandom();
            b = $urandom() >> $urandom_range(0, DATA_WIDTH - 2);  // divisors of every size.
            if ($urandom() % 2 == 1) b = -b;
            for (int c = 4; c < 8; c++) runOp(MulDivCommand'(c), a, b, 0, 0);
        end
    endtask

    task automatic testSpecialCases();
        for (int c = 4; c < 8; c++) begin
            runOp(MulDivCommand'(c), MOST_NEGATIVE, '0, 0, 0);
            runOp(MulDivCommand'(c), 32'h1234abcd, '0, 0, 0);
            runOp(MulDivCommand'(c), MOST_NEGATIVE, '1, 0, 0);  // overflow only when signed.
        end
    endtask

    // the second request waits with reqValid high until the first one is answered.
    task automatic testHandshake();
        logic [DATA_WIDTH-1:0] result;
        int latency;
        sendRequest(MulDivCommand_Mulhu, 32'hdeadbeef, 32'hcafef00d);
        reqValid <= 1'b1;
        reqCommand <= MulDivCommand_Rem;
        reqSrc1 <= 32'h8765_4321;
        reqSrc2 <= 32'h0000_0123;
        waitResponse(0, 0, result, latency);
        checkResult(MulDivCommand_Mulhu, expectedResult(MulDivCommand_Mulhu, 32'hdeadbeef,
            32'hcafef00d), result);
        checkLatency(MulDivCommand_Mulhu, expectedLatency(MulDivCommand_Mulhu, 0), latency);
        @(posedge clk);
        if (!reqReady) begin
            protocolErrors++;
            $display("reqReady did not return high in the cycle after respValid");
            while (!reqReady) @(posedge clk);
        end
        reqValid <= 1'b0;
        waitResponse(0, 0, result, latency);
        checkResult(MulDivCommand_Rem, expectedResult(MulDivCommand_Rem, 32'h8765_4321,
            32'h0000_0123), result);
        checkLatency(MulDivCommand_Rem, expectedLatency(MulDivCommand_Rem, 0), latency);
    endtask

    task automatic testFlush();
        for (int i = 0; i < 10; i++) begin
            if (i == 0) sendRequest(MulDivCommand_Div, 32'hf000_0001, 32'h0000_0007);
            @(posedge clk);
            if (respValid) begin
                protocolErrors++;
                $display("respValid came early for a divide at %0t ns", $time);
            end
        end
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        // the cancelled divide would have finished within this window.
        for (int i = 0; i < DIV_CYCLES + 5; i++) begin
            @(posedge clk);
            if (respValid) begin
                protocolErrors++;
                $display("respValid appeared at %0t ns after the divide was flushed", $time);
            end
        end
        runOp(MulDivCommand_Mulhsu, MOST_NEGATIVE, 32'h1234_5678, 0, 0);
    endtask

    initial begin
        int seedValue;
        seedValue = $urandom(32'h743d);
        corners = '{'0, 1, '1, MOST_NEGATIVE, MOST_POSITIVE};
        clk = 1'b0;
        rstN = 1'b0;
        reqValid = 1'b0;
        reqCommand = MulDivCommand_Mul;
        reqSrc1 = '0;
        reqSrc2 = '0;
        stall = 1'b0;
        flush = 1'b0;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        if (!reqReady || respValid !== 1'b0) begin
            protocolErrors++;
            $display("after reset reqReady is not high or respValid is not low");
        end

        testMultiplies();
        testDivides();
        testSpecialCases();
        testHandshake();
        runOp(MulDivCommand_Mulh, 32'h8000_1234, 32'h7fff_5678, 2, 3);  // stalled multiply.
        runOp(MulDivCommand_Divu, 32'hfedc_ba98, 32'h0000_0345, 10, 7);  // stalled divide.
        testFlush();

        $display("errors: %0d result, %0d latency, %0d protocol",
            resultErrors, latencyErrors, protocolErrors);
        if (resultErrors + latencyErrors + protocolErrors == 0) begin
            $display("Test passed");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* MulDivIf.sv */
`timescale 1ns/1ps
`default_nettype none

// request and response between the issue stage and the execute block.
interface MulDivIf;
    import MulDivTypes::*;

    MulDivCommand command;          // held from enable until done.
    logic [DATA_WIDTH-1:0] src1;    // first operand, held with the command.
    logic [DATA_WIDTH-1:0] src2;    // second operand, held with the command.
    logic enable;                   // starts the operation.
    logic stall;                    // freezes every register in the units.
    logic flush;                    // cancels the running operation.
    logic done;                     // result is valid in this cycle.
    logic [DATA_WIDTH-1:0] result;  // selected by the held command.

    // the issue side owns the request.
    modport issue (
        output command,
        output src1,
        output src2,
        output enable,
        output stall,
        output flush,
        input done,
        input result
    );

    // the execute side answers it.
    modport exec (
        input command,
        input src1,
        input src2,
        input enable,
        input stall,
        input flush,
        output done,
        output result
    );
endinterface

`default_nettype wire

/* MulDivIssueStage.sv */
`timescale 1ns/1ps
`default_nettype none

module MulDivIssueStage (
    input logic clk,
    input logic rstN,
    input logic reqValid,
    output logic reqReady,
    input MulDivTypes::MulDivCommand reqCommand,
    input logic [MulDivTypes::DATA_WIDTH-1:0] reqSrc1,
    input logic [MulDivTypes::DATA_WIDTH-1:0] reqSrc2,
    input logic stall,
    input logic flush,
    MulDivIf.issue port
);
    import MulDivTypes::*;

    logic busy;    // an operation is held in the units.
    logic accept;  // a request is taken at the coming edge.

    // only one operation may be in flight, since the result is picked by the held command.
    assign reqReady = !busy && !flush;
    assign accept = reqValid && reqReady;

    // stall and flush reach the units unchanged.
    assign port.stall = stall;
    assign port.flush = flush;

    // the command and operands stay put until the next request is taken.
    always_ff @(posedge clk) begin
        if (accept) begin
            port.command <= reqCommand;
            port.src1 <= reqSrc1;
            port.src2 <= reqSrc2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            port.enable <= 1'b0;
        end
        else if (flush) begin
            busy <= 1'b0;  // the units drop the operation as well.
            port.enable <= 1'b0;
        end
        else begin
            if (accept) begin
                busy <= 1'b1;
            end
            else if (port.done && !stall) begin
                busy <= 1'b0;  // the core sees the response in this cycle.
            end

            // enable is a single pulse, but it waits out a stall so the units really see it.
            if (accept) begin
                port.enable <= 1'b1;
            end
            else if (!stall) begin
                port.enable <= 1'b0;
            end
        end
    end

    // a second request must wait until the first one has left the units.
    assert property (@(posedge clk) disable iff (!rstN) (port.enable || port.done) |-> !reqReady)
        else $error("reqReady is high while an operation is in the units");
endmodule

`default_nettype wire

/* MulDivTypes.sv */
`default_nettype none

package MulDivTypes;

    // the command encoding follows funct3 of the RV32M opcodes.
    // bit 2 splits the multiplier from the divider.
    typedef enum logic [2:0] {
        MulDivCommand_Mul    = 3'b000,  // low word of the signed product.
        MulDivCommand_Mulh   = 3'b001,  // high word, both operands signed.
        MulDivCommand_Mulhsu = 3'b010,  // high word, src1 signed and src2 unsigned.
        MulDivCommand_Mulhu  = 3'b011,  // high word, both operands unsigned.
        MulDivCommand_Div    = 3'b100,  // signed quotient.
        MulDivCommand_Divu   = 3'b101,  // unsigned quotient.
        MulDivCommand_Rem    = 3'b110,  // signed remainder.
        MulDivCommand_Remu   = 3'b111   // unsigned remainder.
    } MulDivCommand;

    // width of the operands and of the result word.
    localparam int DATA_WIDTH = 32;

    // register stages of the multiplier, from the enable cycle to done.
    localparam int MUL_STAGES = 3;

    // the divider spends one cycle to set up, one per quotient bit
    // and one more to apply the signs.
    localparam int DIV_CYCLES = DATA_WIDTH + 2;

endpackage

`default_nettype wire

/* MulDivUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module MulDivUnit (
    input logic clk,
    input logic rstN,
    MulDivIf.exec port
);
    import MulDivTypes::*;

    logic mulDone;
    logic [DATA_WIDTH-1:0] mulResult;
    logic mulHigh;        // the command wants the upper product word.
    logic mulSrcSigned1;
    logic mulSrcSigned2;

    logic divDone;
    logic [DATA_WIDTH-1:0] quotient;
    logic [DATA_WIDTH-1:0] remnant;
    logic divSigned;

    MulUnit m_MulUnit (
        .clk,
        .rstN,
        .enable(port.enable),
        .stall(port.stall),
        .flush(port.flush),
        .high(mulHigh),
        .srcSigned1(mulSrcSigned1),
        .srcSigned2(mulSrcSigned2),
        .src1(port.src1),
        .src2(port.src2),
        .done(mulDone),
        .result(mulResult)
    );

    DivUnit #(
        .N(DATA_WIDTH)
    ) m_DivUnit (
        .clk,
        .rstN,
        .enable(port.enable),
        .stall(port.stall),
        .flush(port.flush),
        .isSigned(divSigned),
        .dividend(port.src1),
        .divisor(port.src2),
        .done(divDone),
        .quotient,
        .remnant
    );

    // both units start on every enable, only the selected one is listened to.
    always_comb begin
        mulHigh = (port.command == MulDivCommand_Mulh) || (port.command == MulDivCommand_Mulhsu)
            || (port.command == MulDivCommand_Mulhu);
        mulSrcSigned1 = (port.command == MulDivCommand_Mulh)
            || (port.command == MulDivCommand_Mulhsu);
        mulSrcSigned2 = (port.command == MulDivCommand_Mulh);
        divSigned = (port.command == MulDivCommand_Div) || (port.command == MulDivCommand_Rem);
    end

    always_comb begin
        case (port.command)
            MulDivCommand_Div, MulDivCommand_Divu: begin
                port.done = divDone;
                port.result = quotient;
            end
            MulDivCommand_Rem, MulDivCommand_Remu: begin
                port.done = divDone;
                port.result = remnant;
            end
            default: begin
                port.done = mulDone;  // the four multiply commands.
                port.result = mulResult;
            end
        endcase
    end
endmodule

`default_nettype wire

/* MulUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module MulUnit (
    input logic clk,
    input logic rstN,
    input logic enable,
    input logic stall,
    input logic flush,
    input logic high,
    input logic srcSigned1,
    input logic srcSigned2,
    input logic [MulDivTypes::DATA_WIDTH-1:0] src1,
    input logic [MulDivTypes::DATA_WIDTH-1:0] src2,
    output logic done,
    output logic [MulDivTypes::DATA_WIDTH-1:0] result
);
    import MulDivTypes::*;

    // stage 1 holds both operands widened by one sign bit.
    logic valid1;
    logic high1;
    logic [DATA_WIDTH:0] opA1;
    logic [DATA_WIDTH:0] opB1;

    // stage 2 holds the four partial products of the half words.
    logic valid2;
    logic high2;
    logic [DATA_WIDTH-1:0] prodLL2;          // low times low, unsigned.
    logic signed [DATA_WIDTH+1:0] prodLH2;   // low of A times the signed high of B.
    logic signed [DATA_WIDTH+1:0] prodHL2;   // signed high of A times low of B.
    logic signed [DATA_WIDTH+1:0] prodHH2;   // high times high, both signed.

    // the partial products aligned to their weight and summed.
    logic [2*DATA_WIDTH+1:0] termHH;
    logic [2*DATA_WIDTH+1:0] termLH;
    logic [2*DATA_WIDTH+1:0] termHL;
    logic [2*DATA_WIDTH+1:0] termLL;
    logic [2*DATA_WIDTH+1:0] product;

    always_comb begin
        termHH = {prodHH2, {DATA_WIDTH{1'b0}}};
        termLH = {{(DATA_WIDTH/2){prodLH2[DATA_WIDTH+1]}}, prodLH2, {(DATA_WIDTH/2){1'b0}}};
        termHL = {{(DATA_WIDTH/2){prodHL2[DATA_WIDTH+1]}}, prodHL2, {(DATA_WIDTH/2){1'b0}}};
        termLL = {{(DATA_WIDTH+2){1'b0}}, prodLL2};
        product = termHH + termLH + termHL + termLL;  // wraps correctly in 66 bits.
    end

    // the valid bits move with the data, a flush empties every stage.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            done <= 1'b0;
        end
        else if (flush) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            done <= 1'b0;
        end
        else if (!stall) begin
            valid1 <= enable;
            valid2 <= valid1;
            done <= valid2;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            // an unsigned operand gets a zero on top, so one signed array covers all cases.
            opA1 <= {srcSigned1 & src1[DATA_WIDTH-1], src1};
            opB1 <= {srcSigned2 & src2[DATA_WIDTH-1], src2};
            high1 <= high;

            prodLL2 <= opA1[DATA_WIDTH/2-1:0] * opB1[DATA_WIDTH/2-1:0];
            prodLH2 <= $signed({1'b0, opA1[DATA_WIDTH/2-1:0]})
                * $signed(opB1[DATA_WIDTH:DATA_WIDTH/2]);
            prodHL2 <= $signed(opA1[DATA_WIDTH:DATA_WIDTH/2])
                * $signed({1'b0, opB1[DATA_WIDTH/2-1:0]});
            prodHH2 <= $signed(opA1[DATA_WIDTH:DATA_WIDTH/2])
                * $signed(opB1[DATA_WIDTH:DATA_WIDTH/2]);
            high2 <= high1;

            result <= high2 ? product[2*DATA_WIDTH-1:DATA_WIDTH] : product[DATA_WIDTH-1:0];
        end
    end

    // the issue stage keeps a single operation in flight.
    assert property (@(posedge clk) disable iff (!rstN) enable |-> !valid1)
        else $error("enable while stage 1 is still occupied");

    // without stall, done follows the enable cycle after exactly MUL_STAGES cycles.
    assert property (@(posedge clk) disable iff (!rstN || flush)
        (enable && !stall) ##1 (!stall)[*(MUL_STAGES-1)] |=> done)
        else $error("multiplier latency differs from MUL_STAGES");
endmodule

`default_nettype wire

/* vlog.f */
MulDivTypes.sv
MulDivIf.sv
MulDivIssueStage.sv
MulUnit.sv
DivUnit.sv
MulDivUnit.sv
MulDivCore.sv
MulDivCoreTb.sv
